//--- design/csr_issue_ctrl.sv
module csr_issue_ctrl (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  csr_op_pkg::csr_req_t                 req,
    input  logic                                 stall,
    input  logic                                 flush,
    input  logic [8:0]                           int_lines,
    input  logic                                 timer_int,
    input  csr_map_pkg::crmd_t                   crmd,
    input  logic [csr_map_pkg::INT_LINES-1:0]    ecfg_lie,
    input  logic [1:0]                           estat_is,
    input  logic [31:0]                          eentry,
    input  logic [31:0]                          era,
    input  logic [31:0]                          rd_value,
    output csr_map_pkg::csr_num_t                rd_num,
    output logic [31:0]                          rdata,
    output csr_op_pkg::csr_redirect_t            redirect,
    output csr_op_pkg::csr_commit_t              commit
);
    import csr_map_pkg::*;
    import csr_op_pkg::*;

    typedef enum logic [1:0] {
        READY,
        TRAP_PENDING,
        ERTN_PENDING
    } state_t;

    state_t        state;
    state_t        state_next;
    logic          int_pending;
    logic          int_taken;
    logic          accept;
    logic [31:0]   merged;
    logic [31:0]   rdata_next;
    csr_commit_t   commit_next;
    csr_redirect_t redirect_next;

    assign rd_num = req.num;
    assign accept = req.valid && !stall && !flush;

    assign int_pending = |(estat_is_of(int_lines, timer_int, estat_is) & ecfg_lie) && crmd.ie;
    // crmd is about to change while a trap or ertn is committing
    assign int_taken = int_pending && state == READY;

    assign merged = (req.kind == CSR_XCHG) ?
                    ((req.wdata & req.wmask) | (rd_value & ~req.wmask)) : req.wdata;

    always_comb
    begin
        commit_next = '0;
        redirect_next = '0;
        rdata_next = '0;
        if (int_taken)
        begin
            commit_next.valid = 1'b1;
            commit_next.trap = 1'b1;
            commit_next.ecode = ECODE_INT;
            commit_next.era = req.pc;
        end
        else if (accept && req.excp)
        begin
            commit_next.valid = 1'b1;
            commit_next.trap = 1'b1;
            commit_next.ecode = req.ecode;
            commit_next.esubcode = req.esubcode;
            commit_next.era = req.pc;
            commit_next.badv_we = req.ecode == ECODE_ALE;
            commit_next.badv = req.badv;
        end
        else if (accept && req.kind != CSR_NONE)
        begin
            commit_next.valid = 1'b1;
            commit_next.ertn = req.kind == CSR_ERTN;
            commit_next.wr = req.kind == CSR_WR || req.kind == CSR_XCHG;
            commit_next.num = req.num;
            commit_next.wvalue = merged & wmask_of(req.num);
            rdata_next = rd_value;
        end

        if (commit_next.trap)
            redirect_next = '{valid: 1'b1, pc: {eentry[31:6], 6'b0}};
        else if (commit_next.ertn)
            redirect_next = '{valid: 1'b1, pc: era};
        else if (commit_next.wr)
            redirect_next = '{valid: 1'b1, pc: req.pc + 32'd4};

        if (commit_next.trap)
            state_next = TRAP_PENDING;
        else if (commit_next.ertn)
            state_next = ERTN_PENDING;
        else
            state_next = READY;
    end

    // commit_next is empty under stall, so a registered commit lands once
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state <= READY;
            rdata <= '0;
            redirect <= '0;
            commit <= '0;
        end
        else
        begin
            state <= state_next;
            commit <= commit_next;
            if (int_taken || flush || !stall)
            begin
                rdata <= rdata_next;
                redirect <= redirect_next;
            end
        end
    end

    a_rd_no_redirect: assert property (@(posedge clk) disable iff (!rstn)
        commit.valid && !commit.trap && !commit.ertn && !commit.wr |-> !redirect.valid);

    a_trap_xor_ertn: assert property (@(posedge clk) disable iff (!rstn)
        !(commit.trap && commit.ertn));

endmodule

//--- design/csr_map_pkg.sv
package csr_map_pkg;

    typedef logic [13:0] csr_num_t;

    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    localparam int TIMER_W   = 32;
    localparam int INT_LINES = 13;

    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic [22:0] pad;
        crmd_t       f;
    } crmd_word_t;

    typedef struct packed {
        logic       pie;
        logic [1:0] pplv;
    } prmd_t;

    typedef struct packed {
        logic                 pad31;
        logic [8:0]           esubcode;
        logic [5:0]           ecode;
        logic [2:0]           pad;
        logic [INT_LINES-1:0] is;
    } estat_t;

    typedef struct packed {
        logic [TIMER_W-3:0] initval;
        logic               periodic;
        logic               en;
    } tcfg_t;

    // writable bits, everything else reads back zero
    localparam logic [31:0] WMASK_CRMD   = 32'h0000_01ff;
    localparam logic [31:0] WMASK_PRMD   = 32'h0000_0007;
    localparam logic [31:0] WMASK_ECFG   = 32'h0000_1bff;
    localparam logic [31:0] WMASK_ESTAT  = 32'h0000_0003;
    localparam logic [31:0] WMASK_ERA    = 32'hffff_ffff;
    localparam logic [31:0] WMASK_BADV   = 32'hffff_ffff;
    localparam logic [31:0] WMASK_EENTRY = 32'hffff_ffc0;
    localparam logic [31:0] WMASK_SAVE   = 32'hffff_ffff;
    localparam logic [31:0] WMASK_TID    = 32'hffff_ffff;
    localparam logic [31:0] WMASK_TCFG   = 32'hffff_ffff;
    localparam logic [31:0] WMASK_TICLR  = 32'h0000_0001;

    function automatic logic [31:0] wmask_of(csr_num_t num);
        case (num)
            CSR_CRMD:   return WMASK_CRMD;
            CSR_PRMD:   return WMASK_PRMD;
            CSR_ECFG:   return WMASK_ECFG;
            CSR_ESTAT:  return WMASK_ESTAT;
            CSR_ERA:    return WMASK_ERA;
            CSR_BADV:   return WMASK_BADV;
            CSR_EENTRY: return WMASK_EENTRY;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return WMASK_SAVE;
            CSR_TID:    return WMASK_TID;
            CSR_TCFG:   return WMASK_TCFG;
            CSR_TICLR:  return WMASK_TICLR;
            default:    return '0;
        endcase
    endfunction

    // ipi, timer, reserved, 8 hw lines, 2 sw bits
    function automatic logic [INT_LINES-1:0] estat_is_of(logic [8:0] lines, logic ti,
                                                         logic [1:0] sw);
        return {lines[8], ti, 1'b0, lines[7:0], sw};
    endfunction

endpackage

//--- design/csr_op_pkg.sv
package csr_op_pkg;

    typedef enum logic [2:0] {
        CSR_RD,
        CSR_WR,
        CSR_XCHG,
        CSR_ERTN,
        CSR_NONE
    } csr_kind_t;

    typedef logic [5:0] ecode_t;

    localparam ecode_t ECODE_INT = 6'h0;
    localparam ecode_t ECODE_ALE = 6'h9;
    localparam ecode_t ECODE_SYS = 6'hb;
    localparam ecode_t ECODE_BRK = 6'hc;
    localparam ecode_t ECODE_INE = 6'hd;

    typedef struct packed {
        logic                  valid;
        csr_kind_t             kind;
        csr_map_pkg::csr_num_t num;
        logic [31:0]           wdata;
        logic [31:0]           wmask;
        logic [31:0]           pc;
        logic                  excp;
        ecode_t                ecode;
        logic [8:0]            esubcode;
        logic [31:0]           badv;
    } csr_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } csr_redirect_t;

    // wvalue already merged and limited to the writable bits
    typedef struct packed {
        logic                  valid;
        logic                  trap;
        logic                  ertn;
        logic                  wr;
        csr_map_pkg::csr_num_t num;
        logic [31:0]           wvalue;
        ecode_t                ecode;
        logic [8:0]            esubcode;
        logic [31:0]           era;
        logic                  badv_we;
        logic [31:0]           badv;
    } csr_commit_t;

endpackage

//--- design/csr_regfile.sv
module csr_regfile (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  csr_op_pkg::csr_commit_t              commit,
    input  csr_map_pkg::csr_num_t                rd_num,
    input  logic [8:0]                           int_lines,
    input  csr_map_pkg::tcfg_t                   tcfg,
    input  logic [csr_map_pkg::TIMER_W-1:0]      tval,
    input  logic                                 timer_int,
    output logic [31:0]                          rd_value,
    output csr_map_pkg::crmd_t                   crmd,
    output logic [csr_map_pkg::INT_LINES-1:0]    ecfg_lie,
    output logic [1:0]                           estat_is,
    output logic [31:0]                          eentry,
    output logic [31:0]                          era,
    output logic                                 tcfg_we,
    output logic [31:0]                          tcfg_value,
    output logic                                 ticlr,
    output logic                                 excp_flush,
    output logic                                 ertn_flush
);
    import csr_map_pkg::*;

    prmd_t       prmd;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    estat_t      estat;
    logic [31:0] badv;
    logic [31:0] save [4];
    logic [31:0] tid;
    logic        wr_en;
    logic        trap_en;
    logic        ertn_en;

    assign wr_en = commit.valid && commit.wr;
    assign trap_en = commit.valid && commit.trap;
    assign ertn_en = commit.valid && commit.ertn;

    // timer registers live in csr_timer
    assign tcfg_we = wr_en && commit.num == CSR_TCFG;
    assign tcfg_value = commit.wvalue;
    assign ticlr = wr_en && commit.num == CSR_TICLR && commit.wvalue[0];

    always_comb
    begin
        estat = '0;
        estat.esubcode = estat_esubcode;
        estat.ecode = estat_ecode;
        estat.is = estat_is_of(int_lines, timer_int, estat_is);
    end

    always_comb
    begin
        case (rd_num)
            CSR_CRMD:   rd_value = crmd_word_t'{pad: '0, f: crmd};
            CSR_PRMD:   rd_value = 32'(prmd);
            CSR_ECFG:   rd_value = 32'(ecfg_lie);
            CSR_ESTAT:  rd_value = estat;
            CSR_ERA:    rd_value = era;
            CSR_BADV:   rd_value = badv;
            CSR_EENTRY: rd_value = eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: rd_value = save[rd_num[1:0]];
            CSR_TID:    rd_value = tid;
            CSR_TCFG:   rd_value = 32'(tcfg);
            CSR_TVAL:   rd_value = 32'(tval);
            default:    rd_value = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd <= crmd_t'(9'h008);
            prmd <= '0;
            ecfg_lie <= '0;
            estat_is <= '0;
            estat_ecode <= '0;
            estat_esubcode <= '0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= trap_en;
            ertn_flush <= ertn_en;
            if (trap_en)
            begin
                prmd <= '{pie: crmd.ie, pplv: crmd.plv};
                crmd.plv <= 2'b00;
                crmd.ie <= 1'b0;
                estat_ecode <= commit.ecode;
                estat_esubcode <= commit.esubcode;
            end
            else if (ertn_en)
            begin
                crmd.plv <= prmd.pplv;
                crmd.ie <= prmd.pie;
            end
            else if (wr_en)
            begin
                case (commit.num)
                    CSR_CRMD:  crmd <= crmd_t'(commit.wvalue[8:0]);
                    CSR_PRMD:  prmd <= prmd_t'(commit.wvalue[2:0]);
                    CSR_ECFG:  ecfg_lie <= commit.wvalue[INT_LINES-1:0];
                    CSR_ESTAT: estat_is <= commit.wvalue[1:0];
                    default:   ;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (trap_en)
        begin
            era <= commit.era;
            if (commit.badv_we)
                badv <= commit.badv;
        end
        else if (wr_en)
        begin
            case (commit.num)
                CSR_ERA:    era <= commit.wvalue;
                CSR_BADV:   badv <= commit.wvalue;
                CSR_EENTRY: eentry <= commit.wvalue;
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: save[commit.num[1:0]] <= commit.wvalue;
                CSR_TID:    tid <= commit.wvalue;
                default:    ;
            endcase
        end
    end

    a_one_flush: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush));

endmodule

//--- design/csr_timer.sv
module csr_timer (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              tcfg_we,
    input  logic [31:0]                       tcfg_value,
    input  logic                              ticlr,
    output csr_map_pkg::tcfg_t                tcfg,
    output logic [csr_map_pkg::TIMER_W-1:0]   tval,
    output logic                              timer_int
);
    import csr_map_pkg::*;

    logic               en_q;
    logic [TIMER_W-1:0] reload;

    assign reload = {tcfg.initval, 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            en_q <= 1'b0;
            tval <= '0;
            timer_int <= 1'b0;
        end
        else
        begin
            en_q <= tcfg.en;
            if (tcfg_we)
                tcfg <= tcfg_t'(tcfg_value[TIMER_W-1:0]);

            // enable edges first, then reload or count
            if (tcfg.en && !en_q)
                tval <= reload;
            else if (!tcfg.en && en_q)
                tval <= '0;
            else if (tcfg.en && tval == '0 && tcfg.periodic)
                tval <= reload;
            else if (tcfg.en && tval != '1)
                tval <= tval - 1'b1;

            // sticky until cleared through ticlr
            if (ticlr)
                timer_int <= 1'b0;
            else if (tcfg.en && en_q && tval == '0)
                timer_int <= 1'b1;
        end
    end

    a_tval_idle: assert property (@(posedge clk) disable iff (!rstn)
        !tcfg.en && !en_q |=> $stable(tval));

endmodule

//--- design/csr_unit.sv
module csr_unit (
    input  logic                        clk,
    input  logic                        rstn,
    input  csr_op_pkg::csr_req_t        req,
    input  logic                        stall,
    input  logic                        flush,
    input  logic [8:0]                  int_lines,
    output logic [31:0]                 rdata,
    output csr_op_pkg::csr_redirect_t   redirect,
    output csr_map_pkg::crmd_t          crmd,
    output logic                        excp_flush,
    output logic                        ertn_flush
);
    import csr_map_pkg::*;
    import csr_op_pkg::*;

    csr_commit_t          commit;
    csr_num_t             rd_num;
    logic [31:0]          rd_value;
    logic [INT_LINES-1:0] ecfg_lie;
    logic [1:0]           estat_is;
    logic [31:0]          eentry;
    logic [31:0]          era;
    logic                 tcfg_we;
    logic [31:0]          tcfg_value;
    logic                 ticlr;
    tcfg_t                tcfg;
    logic [TIMER_W-1:0]   tval;
    logic                 timer_int;

    csr_issue_ctrl i_issue_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .stall     (stall),
        .flush     (flush),
        .int_lines (int_lines),
        .timer_int (timer_int),
        .crmd      (crmd),
        .ecfg_lie  (ecfg_lie),
        .estat_is  (estat_is),
        .eentry    (eentry),
        .era       (era),
        .rd_value  (rd_value),
        .rd_num    (rd_num),
        .rdata     (rdata),
        .redirect  (redirect),
        .commit    (commit)
    );

    csr_timer i_timer (
        .clk        (clk),
        .rstn       (rstn),
        .tcfg_we    (tcfg_we),
        .tcfg_value (tcfg_value),
        .ticlr      (ticlr),
        .tcfg       (tcfg),
        .tval       (tval),
        .timer_int  (timer_int)
    );

    csr_regfile i_regfile (
        .clk        (clk),
        .rstn       (rstn),
        .commit     (commit),
        .rd_num     (rd_num),
        .int_lines  (int_lines),
        .tcfg       (tcfg),
        .tval       (tval),
        .timer_int  (timer_int),
        .rd_value   (rd_value),
        .crmd       (crmd),
        .ecfg_lie   (ecfg_lie),
        .estat_is   (estat_is),
        .eentry     (eentry),
        .era        (era),
        .tcfg_we    (tcfg_we),
        .tcfg_value (tcfg_value),
        .ticlr      (ticlr),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_unit \
    -f verilog.f -o sim_csr_unit

./obj_dir/sim_csr_unit 2>&1 | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- test/tb_csr_checks.svh
`ifndef TB_CSR_CHECKS_SVH
`define TB_CSR_CHECKS_SVH

// stored CSR values as the pipeline should see them
logic [31:0] shadow [csr_num_t];

function automatic logic [31:0] writable_bits(csr_num_t num);
    case (num)
        CSR_CRMD:   return WMASK_CRMD;
        CSR_PRMD:   return WMASK_PRMD;
        CSR_ECFG:   return WMASK_ECFG;
        CSR_ERA:    return WMASK_ERA;
        CSR_BADV:   return WMASK_BADV;
        CSR_EENTRY: return WMASK_EENTRY;
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return WMASK_SAVE;
        CSR_TID:    return WMASK_TID;
        CSR_TCFG:   return WMASK_TCFG;
        default:    return '0;
    endcase
endfunction

function automatic logic [31:0] model_read(csr_num_t num);
    if (!shadow.exists(num))
        return '0;
    return shadow[num];
endfunction

function automatic void csr_model_next(input csr_req_t r, output logic [31:0] exp_rdata,
                                       output csr_redirect_t exp_redir);
    logic [31:0] old;
    logic [31:0] crmd_v;
    logic [31:0] prmd_v;
    logic [31:0] merged;
    old = model_read(r.num);
    crmd_v = shadow[CSR_CRMD];
    prmd_v = shadow[CSR_PRMD];
    exp_rdata = '0;
    exp_redir = '0;
    if (r.excp)
    begin
        // trap entry saves plv/ie and clears them
        shadow[CSR_PRMD] = {29'b0, crmd_v[2:0]};
        shadow[CSR_CRMD] = crmd_v & ~32'h7;
        shadow[CSR_ERA] = r.pc;
        shadow[CSR_ESTAT] = {1'b0, r.esubcode, r.ecode, shadow[CSR_ESTAT][15:0]};
        if (r.ecode == ECODE_ALE)
            shadow[CSR_BADV] = r.badv;
        exp_redir.valid = 1'b1;
        exp_redir.pc = model_read(CSR_EENTRY) & 32'hffff_ffc0;
        return;
    end
    exp_rdata = old;
    if (r.kind == CSR_ERTN)
    begin
        shadow[CSR_CRMD] = {crmd_v[31:3], prmd_v[2:0]};
        exp_redir.valid = 1'b1;
        exp_redir.pc = model_read(CSR_ERA);
    end
    else if (r.kind == CSR_WR || r.kind == CSR_XCHG)
    begin
        merged = (r.kind == CSR_XCHG) ? ((r.wdata & r.wmask) | (old & ~r.wmask)) : r.wdata;
        if (writable_bits(r.num) != '0)
            shadow[r.num] = merged & writable_bits(r.num);
        exp_redir.valid = 1'b1;
        exp_redir.pc = r.pc + 32'd4;
    end
endfunction

task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp)
    begin
        $display("Mismatch %s: expected %h got %h", name, exp, got);
        fail_now("data compare failed");
    end
endtask

task automatic check_redirect(input csr_redirect_t exp, input csr_redirect_t got);
    if (got.valid !== exp.valid || (exp.valid && got.pc !== exp.pc))
    begin
        $display("Mismatch redirect: expected %h got %h", exp, got);
        fail_now("redirect compare failed");
    end
endtask

`endif

//--- test/tb_csr_unit.sv
module tb_csr_unit;
    timeunit 1ns;
    timeprecision 1ps;

    import csr_map_pkg::*;
    import csr_op_pkg::*;

    localparam int NUM_REQS   = 100;
    localparam int TIMER_INIT = 32;
    localparam int LIMIT      = NUM_REQS * 3 + TIMER_INIT + 200;

    logic          clk = 1'b0;
    logic          rstn;
    csr_req_t      req;
    logic          stall;
    logic          flush;
    logic [8:0]    int_lines;
    logic [31:0]   rdata;
    csr_redirect_t redirect;
    crmd_t         crmd;
    logic          excp_flush;
    logic          ertn_flush;

    logic [31:0]   exp_rdata_q [$];
    csr_redirect_t exp_redir_q [$];
    logic          chk_q [$];
    logic [31:0]   pc_cnt = 32'h1c00_0000;
    logic [31:0]   last_rdata;
    int            cycle_cnt = 0;
    int            issue_cycle = 0;
    int            excp_cnt = 0;
    int            ertn_cnt = 0;

    csr_unit i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .stall      (stall),
        .flush      (flush),
        .int_lines  (int_lines),
        .rdata      (rdata),
        .redirect   (redirect),
        .crmd       (crmd),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    `include "tb_csr_checks.svh"

    always #50 clk = ~clk;

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    always @(negedge clk)
    begin
        if (excp_flush)
            excp_cnt++;
        if (ertn_flush)
            ertn_cnt++;
    end

    // one request every three cycles with rdata kept for the caller
    task automatic send(input csr_req_t r, input logic chk);
        logic [31:0]   exp_d;
        csr_redirect_t exp_r;
        @(posedge clk);
        req <= r;
        issue_cycle = cycle_cnt;
        csr_model_next(r, exp_d, exp_r);
        exp_rdata_q.push_back(exp_d);
        exp_redir_q.push_back(exp_r);
        chk_q.push_back(chk);
        @(posedge clk);
        req.valid <= 1'b0;
        @(negedge clk);
        last_rdata = rdata;
        @(posedge clk);
    endtask

    task automatic issue(input csr_kind_t kind, input csr_num_t num, input logic [31:0] wdata,
                         input logic [31:0] wmask, input logic chk);
        csr_req_t r;
        r = '0;
        r.valid = 1'b1;
        r.kind = kind;
        r.num = num;
        r.wdata = wdata;
        r.wmask = wmask;
        r.pc = pc_cnt;
        pc_cnt = pc_cnt + 32'd4;
        send(r, chk);
    endtask

    task automatic wait_timer_bit(input int start);
        logic seen;
        seen = 1'b0;
        while (!seen)
        begin
            issue(CSR_RD, CSR_ESTAT, '0, '0, 1'b0);
            seen = last_rdata[11];
            if (!seen && issue_cycle - start >= TIMER_INIT + 4)
                fail_now("timer interrupt bit did not set in time");
        end
    endtask

    // compares one cycle after each accepted request
    initial
    begin
        logic [31:0]   exp_d;
        csr_redirect_t exp_r;
        logic          chk;
        forever
        begin
            @(negedge clk);
            if (rstn && req.valid)
            begin
                exp_d = exp_rdata_q.pop_front();
                exp_r = exp_redir_q.pop_front();
                chk = chk_q.pop_front();
                @(negedge clk);
                check_redirect(exp_r, redirect);
                if (chk)
                    check_data("rdata", exp_d, rdata);
            end
        end
    end

    initial
    begin
        #(LIMIT * 100);
        fail_now("simulation timed out waiting for the tests to finish");
    end

    initial
    begin
        csr_num_t      wr_list [7];
        csr_req_t      r;
        logic [31:0]   exp_d;
        csr_redirect_t exp_r;
        logic [31:0]   t0;
        int            start;
        wr_list = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA, CSR_EENTRY, CSR_ECFG};
        void'($urandom(20));
        rstn = 1'b0;
        req = '0;
        stall = 1'b0;
        flush = 1'b0;
        int_lines = '0;
        shadow[CSR_CRMD] = 32'h8;
        shadow[CSR_PRMD] = '0;
        shadow[CSR_ECFG] = '0;
        shadow[CSR_ESTAT] = '0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        check_data("crmd", 32'h8, 32'(crmd));

        foreach (wr_list[i])
            issue(CSR_WR, wr_list[i], $urandom(), '0, 1'b0);
        foreach (wr_list[i])
            issue(CSR_RD, wr_list[i], '0, '0, 1'b1);

        issue(CSR_XCHG, CSR_SAVE1, $urandom(), $urandom(), 1'b1);
        issue(CSR_RD, CSR_SAVE1, '0, '0, 1'b1);

        // exception entry and return with ie set
        issue(CSR_WR, CSR_ECFG, '0, '0, 1'b1);
        issue(CSR_WR, CSR_CRMD, 32'hc, '0, 1'b1);
        r = '0;
        r.valid = 1'b1;
        r.kind = CSR_NONE;
        r.pc = pc_cnt;
        r.excp = 1'b1;
        r.ecode = ECODE_ALE;
        r.esubcode = 9'h1;
        r.badv = $urandom();
        pc_cnt = pc_cnt + 32'd4;
        send(r, 1'b1);
        @(negedge clk);
        @(negedge clk);
        check_data("excp_flush count", 32'd1, 32'(excp_cnt));
        check_data("crmd.ie", 32'd0, 32'(crmd.ie));
        issue(CSR_RD, CSR_ERA, '0, '0, 1'b1);
        issue(CSR_RD, CSR_BADV, '0, '0, 1'b1);
        issue(CSR_RD, CSR_PRMD, '0, '0, 1'b1);
        issue(CSR_RD, CSR_ESTAT, '0, '0, 1'b0);
        check_data("estat.ecode", 32'(ECODE_ALE), 32'(last_rdata[21:16]));
        issue(CSR_ERTN, CSR_CRMD, '0, '0, 1'b1);
        @(negedge clk);
        @(negedge clk);
        check_data("ertn_flush count", 32'd1, 32'(ertn_cnt));
        check_data("crmd.ie", 32'd1, 32'(crmd.ie));

        // hardware line 0 is ESTAT.IS bit 2
        issue(CSR_WR, CSR_ECFG, 32'h4, '0, 1'b1);
        r = req;
        r.excp = 1'b1;
        r.ecode = ECODE_INT;
        r.esubcode = '0;
        csr_model_next(r, exp_d, exp_r);
        @(posedge clk);
        int_lines <= 9'h001;
        repeat (20)
        begin
            @(negedge clk);
            if (redirect.valid)
                break;
        end
        if (!redirect.valid)
            fail_now("no redirect after the hardware interrupt");
        check_redirect(exp_r, redirect);
        @(posedge clk);
        int_lines <= '0;
        repeat (3) @(posedge clk);
        issue(CSR_RD, CSR_ESTAT, '0, '0, 1'b0);
        check_data("estat.ecode", 32'(ECODE_INT), 32'(last_rdata[21:16]));
        @(posedge clk);
        int_lines <= 9'h001;
        repeat (20)
        begin
            @(negedge clk);
            if (redirect.valid)
                fail_now("interrupt taken while CRMD.ie is clear");
        end
        @(posedge clk);
        int_lines <= '0;

        // one-shot timer ignores the low two bits of the initial value
        issue(CSR_WR, CSR_ECFG, '0, '0, 1'b1);
        issue(CSR_WR, CSR_TCFG, TIMER_INIT | 32'h1, '0, 1'b1);
        start = issue_cycle;
        issue(CSR_RD, CSR_TVAL, '0, '0, 1'b0);
        t0 = last_rdata;
        issue(CSR_RD, CSR_TVAL, '0, '0, 1'b0);
        if (!(last_rdata < t0))
            fail_now("TVAL did not count down");
        wait_timer_bit(start);
        issue(CSR_WR, CSR_TICLR, 32'h1, '0, 1'b1);
        issue(CSR_RD, CSR_ESTAT, '0, '0, 1'b0);
        check_data("estat.is timer", 32'd0, 32'(last_rdata[11]));

        // periodic mode sets the flag again after a clear
        issue(CSR_WR, CSR_TCFG, '0, '0, 1'b1);
        issue(CSR_WR, CSR_TCFG, TIMER_INIT | 32'h3, '0, 1'b1);
        start = issue_cycle;
        wait_timer_bit(start);
        issue(CSR_WR, CSR_TICLR, 32'h1, '0, 1'b1);
        start = issue_cycle;
        wait_timer_bit(start);

        repeat (4) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+test
design/csr_map_pkg.sv
design/csr_op_pkg.sv
design/csr_issue_ctrl.sv
design/csr_timer.sv
design/csr_regfile.sv
design/csr_unit.sv
test/tb_csr_unit.sv
